// ==== list.f ====
+incdir+src
src/retpred_pkg.sv
src/retAddrStack.sv
src/retRecoveryQueue.sv
src/retPredTable.sv
src/returnStack.sv
sim/returnStack_sva.sv
sim/returnStack_tb.sv

// ==== Bender.yml ====
package:
  name: return_stack

sources:
  - include_dirs:
      - src
    files:
      - src/retpred_pkg.sv
      - src/retAddrStack.sv
      - src/retRecoveryQueue.sv
      - src/retPredTable.sv
      - src/returnStack.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/returnStack_sva.sv
      - sim/returnStack_tb.sv

// ==== sim/returnStack_tb.sv ====
`timescale 1ns/1ps
`include "retpred_macros.svh"

module returnStack_tb import retpred_pkg::*; ();

    typedef enum logic [2:0] {
        OpFetch, OpFetchCall, OpFetchRet, OpDecRet, OpDecClean, OpDecCall, OpMispr, OpCommit
    } OpT;

    // arg: fetch reuses the decoded pc if set, decode call address, mispredict id distance
    // exp: predBr.valid for fetch rows, stall length for mispredict rows
    typedef struct packed {
        OpT          op;
        logic [31:0] arg;
        logic [7:0]  exp;
    } RowT;

    logic       clk = 1'b0;
    logic       rst;
    logic       fetchValid;
    PcT         fetchPc;
    FetchIdT    fetchId;
    PcT         lastPc;
    PredBranchT lastBranch;
    FetchIdT    comFetchId;
    MisprT      mispr;
    ReturnUpdT  retUpd;
    logic       stall;
    PcT         curRetAddr;
    RsIdxT      curIdx;
    RetPredT    predBr;

    RowT   rows[$];
    string names[$];

    // reference model of the stack, the index and the recovery queue
    PcT       mStack [`RS_SIZE];
    RsIdxT    mIdx;
    RecEntryT mQueue[$];
    FetchIdT  mComBase;
    FetchIdT  fidCnt;
    RecEntryT lastPop;
    PcT       decPc;
    logic     decCompr;

    logic [31:0] lfsr = 32'h8d4bcde8;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycleLimit = 0;

    returnStack DUT (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .fetchId    (fetchId),
        .lastPc     (lastPc),
        .lastBranch (lastBranch),
        .comFetchId (comFetchId),
        .mispr      (mispr),
        .retUpd     (retUpd),
        .stall      (stall),
        .curRetAddr (curRetAddr),
        .curIdx     (curIdx),
        .predBr     (predBr)
    );

    bind retRecoveryQueue returnStack_sva sva (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            $display("the run timed out after %0d cycles without finishing the table", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] galoisStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end else begin
            return s >> 1;
        end
    endfunction

    task automatic randBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = galoisStep(lfsr);
        end
    endtask

    // wrapped ids are ordered by their distance from a base
    function automatic FetchIdT fidDist(input FetchIdT id, input FetchIdT base);
        return FetchIdT'(id - base);
    endfunction

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkStack(input string name);
        checkVal({name, " index"}, mIdx, curIdx);
        // entries never written hold no defined address
        if (!$isunknown(mStack[mIdx])) begin
            checkVal({name, " address"}, mStack[mIdx], curRetAddr);
            checkVal({name, " dst"}, mStack[mIdx], predBr.dst);
        end
    endtask

    task automatic addRow(input OpT op, input logic [31:0] arg, input logic [7:0] exp,
                          input string name);
        rows.push_back('{op: op, arg: arg, exp: exp});
        names.push_back(name);
    endtask

    task automatic buildTable();
        addRow(OpFetch, 0, 0, "first fetch");
        addRow(OpFetchCall, 0, 0, "call one");
        addRow(OpFetchCall, 0, 0, "call two");
        addRow(OpFetch, 0, 0, "fetch top");
        addRow(OpFetchRet, 0, 0, "return one");
        addRow(OpFetchCall, 0, 0, "wrong path call");
        addRow(OpMispr, 0, 2, "restore one");
        addRow(OpFetch, 0, 0, "after restore");
        addRow(OpDecRet, 0, 0, "insert return");
        addRow(OpFetch, 1, 1, "table hit");
        addRow(OpDecClean, 0, 0, "clean return");
        addRow(OpFetch, 1, 0, "table miss");
        addRow(OpDecCall, 32'h0abc_1230, 0, "decode call");
        addRow(OpFetch, 0, 0, "after decode call");
        addRow(OpFetchRet, 0, 0, "return two");
        addRow(OpCommit, 0, 0, "commit pops");
        addRow(OpMispr, 0, 1, "empty restore");
        addRow(OpFetch, 0, 0, "after empty restore");
        addRow(OpFetchCall, 0, 0, "call three");
        addRow(OpFetchRet, 0, 0, "return three");
        addRow(OpMispr, 2, 2, "restore older id");
        addRow(OpFetch, 0, 0, "after second restore");
        addRow(OpFetchCall, 0, 0, "call four");
        addRow(OpFetch, 0, 0, "random fetch");
        addRow(OpCommit, 0, 0, "final commit");
    endtask

    task automatic driveIdle();
        fetchValid <= 1'b0;
        lastBranch <= '0;
        mispr <= '0;
        retUpd <= '0;
    endtask

    task automatic driveFetch(input PcT pc, input PcT lp, input PredBranchT br);
        @(posedge clk);
        fetchValid <= 1'b1;
        fetchPc <= pc;
        fetchId <= fidCnt;
        lastPc <= lp;
        lastBranch <= br;
        fidCnt = fidCnt + 1'b1;
    endtask

    task automatic settle();
        @(posedge clk);
        driveIdle();
        @(negedge clk);
    endtask

    task automatic applyRow(input RowT r, input string name);
        logic [31:0] rnd;
        logic [31:0] lp;
        PredBranchT  br;
        ReturnUpdT   upd;
        MisprT       mp;
        FetchIdT     misFid;
        int          stallLen;
        br = '0;
        upd = '0;
        mp = '0;
        stallLen = 0;
        randBits(31, rnd);
        case (r.op)
            OpFetch: begin
                driveFetch(r.arg[0] ? {decPc[30:3], 3'b000} : rnd[30:0], '0, '0);
                settle();
                checkStack(name);
                checkVal({name, " valid"}, r.exp, predBr.valid);
                if (r.exp[0]) begin
                    checkVal({name, " offset"}, decPc[2:0], predBr.offs);
                    checkVal({name, " compr"}, decCompr, predBr.compr);
                end
            end
            OpFetchCall, OpFetchRet: begin
                // a call or return only counts after an accepted fetch
                driveFetch(rnd[30:0], '0, '0);
                randBits(31, lp);
                randBits(3, rnd);
                br.valid = 1'b1;
                br.offs = rnd[2:0];
                if (r.op == OpFetchCall) begin
                    br.isCall = 1'b1;
                    mIdx = mIdx + 1'b1;
                    mStack[mIdx] = PcT'({lp[30:3], br.offs} + 1'b1);
                end else begin
                    br.isRet = 1'b1;
                    lastPop = '{addr: mStack[mIdx], idx: mIdx, fetchId: fidCnt};
                    mQueue.push_back(lastPop);
                    if (mQueue.size() > `RQ_SIZE - 1) begin
                        mQueue.delete(0);
                    end
                    mIdx = mIdx - 1'b1;
                end
                driveFetch(lp[30:0] ^ rnd[30:0], lp[30:0], br);
                settle();
                checkStack(name);
            end
            OpDecRet, OpDecClean, OpDecCall: begin
                upd.valid = 1'b1;
                if (r.op == OpDecRet) begin
                    decPc = rnd[30:0];
                    randBits(1, rnd);
                    decCompr = rnd[0];
                end
                upd.addr = decPc;
                upd.compr = decCompr;
                upd.isRet = r.op != OpDecCall;
                upd.cleanRet = r.op == OpDecClean;
                if (r.op == OpDecCall) begin
                    // decode writes addr plus one above the given index
                    upd.addr = r.arg[30:0];
                    upd.idx = mIdx - 1'b1;
                    upd.isCall = 1'b1;
                    mStack[mIdx] = PcT'(r.arg[30:0] + 1'b1);
                end
                @(posedge clk);
                retUpd <= upd;
                settle();
            end
            OpMispr: begin
                misFid = FetchIdT'(lastPop.fetchId - r.arg[4:0]);
                mp = '{valid: 1'b1, idx: lastPop.idx, fetchId: misFid};
                @(posedge clk);
                mispr <= mp;
                settle();
                checkVal({name, " stall rise"}, 1, stall);
                while (stall) begin
                    stallLen++;
                    @(negedge clk);
                end
                checkVal({name, " stall cycles"}, r.exp, stallLen);
                // younger backups go back into the stack, newest first
                while (mQueue.size() > 0 && fidDist(mQueue[$].fetchId, mComBase) >=
                       fidDist(misFid, mComBase)) begin
                    mStack[mQueue[$].idx] = mQueue[$].addr;
                    mQueue.delete(mQueue.size() - 1);
                end
                mIdx = lastPop.idx;
            end
            OpCommit: begin
                @(posedge clk);
                comFetchId <= fidCnt;
                while (mQueue.size() > 0 &&
                       fidDist(mQueue[0].fetchId, mComBase) < fidDist(fidCnt, mComBase)) begin
                    mComBase = mQueue[0].fetchId;
                    mQueue.delete(0);
                end
                mComBase = fidCnt;
                // one entry drains per cycle
                repeat (`RQ_SIZE + 2) @(posedge clk);
                @(negedge clk);
            end
            default: begin
                $display("row %s has an unknown operation", name);
                errors++;
            end
        endcase
    endtask

    initial begin
        rst <= 1'b1;
        fetchValid <= 1'b0;
        fetchPc <= '0;
        fetchId <= '0;
        lastPc <= '0;
        lastBranch <= '0;
        comFetchId <= '0;
        mispr <= '0;
        retUpd <= '0;
        mIdx = '0;
        mComBase = '0;
        fidCnt = '0;
        lastPop = '0;
        decPc = '0;
        decCompr = 1'b0;
        buildTable();
        cycleLimit = 40 * rows.size() + 100;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkVal("reset stall", 0, stall);
        foreach (rows[i]) begin
            applyRow(rows[i], names[i]);
        end
        $display("%0d checks run, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim/returnStack_sva.sv ====
`timescale 1ns/1ps
`include "retpred_macros.svh"

module returnStack_sva import retpred_pkg::*; (
    input logic  clk,
    input logic  rst,
    input MisprT mispr,
    input logic  stall
);

    // the queue leaves reset idle
    stallAfterReset: assert property (@(posedge clk) rst |=> !stall)
        else $error("stall is high right after reset");

    stallOnMispr: assert property (@(posedge clk) disable iff (rst)
        mispr.valid |=> stall)
        else $error("stall did not rise the cycle after a mispredict");

    // a restore pass can not outlast the queue depth
    stallBounded: assert property (@(posedge clk) disable iff (rst)
        $rose(stall) |-> ##[1:`RQ_SIZE] !stall)
        else $error("stall stayed high longer than the recovery queue depth");

endmodule

// ==== src/returnStack.sv ====
`timescale 1ns/1ps

module returnStack import retpred_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       fetchValid,
    input  PcT         fetchPc,
    input  FetchIdT    fetchId,
    input  PcT         lastPc,
    input  PredBranchT lastBranch,
    input  FetchIdT    comFetchId,
    input  MisprT      mispr,
    input  ReturnUpdT  retUpd,
    output logic       stall,
    output PcT         curRetAddr,
    output RsIdxT      curIdx,
    output RetPredT    predBr
);

    RecWrT    popRec;
    RecWrT    restoreWr;
    RtLookupT lookup;

    retAddrStack stackInst (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .lastPc     (lastPc),
        .lastBranch (lastBranch),
        .fetchId    (fetchId),
        .mispr      (mispr),
        .retUpd     (retUpd),
        .restoreWr  (restoreWr),
        .curRetAddr (curRetAddr),
        .curIdx     (curIdx),
        .popRec     (popRec)
    );

    retRecoveryQueue queueInst (
        .clk        (clk),
        .rst        (rst),
        .popRec     (popRec),
        .mispr      (mispr),
        .comFetchId (comFetchId),
        .restoreWr  (restoreWr),
        .stall      (stall)
    );

    retPredTable tableInst (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchPc    (fetchPc),
        .retUpd     (retUpd),
        .lookup     (lookup)
    );

    // both halves are registered on the same accepted fetch
    assign predBr.valid = lookup.valid;
    assign predBr.offs = lookup.offs;
    assign predBr.compr = lookup.compr;
    assign predBr.dst = curRetAddr;

endmodule

// ==== src/retPredTable.sv ====
`timescale 1ns/1ps
`include "retpred_macros.svh"

module retPredTable import retpred_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      fetchValid,
    input  PcT        fetchPc,
    input  ReturnUpdT retUpd,
    output RtLookupT  lookup
);

    localparam int SetBits = $clog2(`RT_SETS);
    localparam int OffBits = $bits(FetchOffT);

    typedef logic [SetBits-1:0] SetIdxT;
    typedef logic [`RT_TAG_LEN-1:0] TagT;
    typedef logic [$clog2(`RT_ASSOC)-1:0] WayT;

    typedef struct packed {
        TagT      tag;
        // offset of the return's last halfword in its fetch block
        FetchOffT offs;
        logic     compr;
        logic     used;
        logic     valid;
    } RtEntryT;

    RtEntryT entries [`RT_SETS][`RT_ASSOC];

    SetIdxT   fetchSet;
    TagT      fetchTag;
    FetchOffT fetchOffs;
    SetIdxT   decSet;
    TagT      decTag;

    RtLookupT hit;
    WayT      insWay;
    logic     insOk;

    always_comb begin
        // xor fold the block address into set and tag
        fetchSet = fetchPc[OffBits +: SetBits] ^ fetchPc[OffBits + 3 +: SetBits];
        fetchTag = fetchPc[OffBits +: `RT_TAG_LEN] ^ fetchPc[OffBits + `RT_TAG_LEN +: `RT_TAG_LEN];
        fetchOffs = fetchPc[OffBits-1:0];

        decSet = retUpd.addr[OffBits +: SetBits] ^ retUpd.addr[OffBits + 3 +: SetBits];
        decTag = retUpd.addr[OffBits +: `RT_TAG_LEN] ^
                 retUpd.addr[OffBits + `RT_TAG_LEN +: `RT_TAG_LEN];
    end

    // first return at or after the fetch offset wins
    always_comb begin
        hit = '0;
        for (int i = 0; i < `RT_ASSOC; i++) begin
            if (entries[fetchSet][i].valid && entries[fetchSet][i].tag == fetchTag &&
                entries[fetchSet][i].offs >= fetchOffs &&
                (!hit.valid || entries[fetchSet][i].offs < hit.offs)) begin
                hit.valid = 1'b1;
                hit.offs = entries[fetchSet][i].offs;
                hit.compr = entries[fetchSet][i].compr;
            end
        end
    end

    always_comb begin
        insWay = '0;
        insOk = 1'b0;
        for (int i = 0; i < `RT_ASSOC; i++) begin
            if (!entries[decSet][i].used || !entries[decSet][i].valid) begin
                insWay = WayT'(i);
                insOk = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lookup.valid <= 1'b0;
            for (int s = 0; s < `RT_SETS; s++) begin
                for (int w = 0; w < `RT_ASSOC; w++) begin
                    entries[s][w].valid <= 1'b0;
                end
            end
        end else begin
            if (fetchValid) begin
                lookup <= hit;
            end

            if (retUpd.valid && retUpd.cleanRet) begin
                // the return turned out not to use the stack
                for (int w = 0; w < `RT_ASSOC; w++) begin
                    if (entries[decSet][w].tag == decTag) begin
                        entries[decSet][w].valid <= 1'b0;
                    end
                end
            end else if (retUpd.valid && retUpd.isRet) begin
                if (insOk) begin
                    entries[decSet][insWay] <= '{tag: decTag, offs: retUpd.addr[OffBits-1:0],
                                                 compr: retUpd.compr, used: 1'b1, valid: 1'b1};
                end else begin
                    // all ways in use, age them so the next insert finds a victim
                    for (int w = 0; w < `RT_ASSOC; w++) begin
                        entries[decSet][w].used <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// ==== src/retRecoveryQueue.sv ====
`timescale 1ns/1ps
`include "retpred_macros.svh"

module retRecoveryQueue import retpred_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  RecWrT   popRec,
    input  MisprT   mispr,
    input  FetchIdT comFetchId,
    output RecWrT   restoreWr,
    output logic    stall
);

    typedef logic [$clog2(`RQ_SIZE)-1:0] QPtrT;

    typedef enum logic {
        Idle,
        Restoring
    } RecStateT;

    RecEntryT queue [`RQ_SIZE];

    // head is the next free slot, tail the oldest backup
    QPtrT     head;
    QPtrT     tail;
    QPtrT     headNext;
    QPtrT     tailNext;
    QPtrT     newest;
    RecStateT state;

    FetchIdT  comBase;
    FetchIdT  recBase;
    FetchIdT  recFetchId;

    logic     empty;
    logic     full;
    logic     keepNewest;
    logic     commitNew;
    logic     doPush;
    logic     doDrain;

    // fetch ids wrap, so they are only compared as distances from a common base
    function automatic FetchIdT relTo(input FetchIdT id, input FetchIdT base);
        return FetchIdT'(id - base);
    endfunction

    always_comb begin
        empty = head == tail;
        full = QPtrT'(head + 1'b1) == tail;
        newest = QPtrT'(head - 1'b1);

        // restore while the newest backup is not older than the mispredict
        keepNewest = relTo(queue[newest].fetchId, recBase) >= relTo(recFetchId, recBase);
        restoreWr.valid = state == Restoring && !empty && keepNewest;
        restoreWr.entry = queue[newest];

        doPush = popRec.valid && state == Idle && !mispr.valid;
        commitNew = state == Idle && !mispr.valid && comBase != comFetchId;
        doDrain = commitNew && !empty &&
                  relTo(queue[tail].fetchId, comBase) < relTo(comFetchId, comBase);

        headNext = head;
        tailNext = tail;
        if (restoreWr.valid) begin
            headNext = newest;
        end
        if (doPush) begin
            headNext = QPtrT'(head + 1'b1);
        end
        // a push into a full queue drops the oldest uncommitted backup
        if (doDrain || (doPush && full)) begin
            tailNext = QPtrT'(tail + 1'b1);
        end
    end

    assign stall = state == Restoring;

    always_ff @(posedge clk) begin
        if (doPush) begin
            queue[head] <= popRec.entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            state <= Idle;
            comBase <= '0;
            recBase <= '0;
            recFetchId <= '0;
        end else begin
            head <= headNext;
            tail <= tailNext;

            if (mispr.valid) begin
                state <= Restoring;
                recFetchId <= mispr.fetchId;
                recBase <= comBase;
            end else if (state == Restoring && !restoreWr.valid) begin
                state <= Idle;
            end

            // no pop between the base and comFetchId means the base can jump
            if (doDrain) begin
                comBase <= queue[tail].fetchId;
            end else if (commitNew) begin
                comBase <= comFetchId;
            end
        end
    end

endmodule

// ==== src/retAddrStack.sv ====
`timescale 1ns/1ps
`include "retpred_macros.svh"

module retAddrStack import retpred_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       fetchValid,
    input  PcT         lastPc,
    input  PredBranchT lastBranch,
    input  FetchIdT    fetchId,
    input  MisprT      mispr,
    input  ReturnUpdT  retUpd,
    input  RecWrT      restoreWr,
    output PcT         curRetAddr,
    output RsIdxT      curIdx,
    output RecWrT      popRec
);

    PcT stack [`RS_SIZE];

    RsIdxT idxReg;
    RsIdxT idx;
    RsIdxT misprIdxQ;
    logic  lastValid;
    logic  fwdIdx;

    logic  callTaken;
    logic  retTaken;
    logic  pushCall;
    logic  decCall;
    PcT    pushAddr;
    RsIdxT decIdx;
    PcT    decAddr;

    always_comb begin
        // previous branch only counts if its fetch was actually accepted
        callTaken = lastBranch.valid && lastBranch.isCall && lastValid;
        retTaken = lastBranch.valid && lastBranch.isRet && lastValid;

        // return address is the halfword after the call's last halfword
        pushAddr = PcT'({lastPc[30:$bits(FetchOffT)], lastBranch.offs} + 1'b1);

        // mispredict index is forwarded for one cycle until it lands in idxReg
        if (fwdIdx) begin
            idx = misprIdxQ;
        end else if (callTaken) begin
            idx = RsIdxT'(idxReg + 1'b1);
        end else if (retTaken) begin
            idx = RsIdxT'(idxReg - 1'b1);
        end else begin
            idx = idxReg;
        end

        pushCall = callTaken && !mispr.valid;
        decCall = retUpd.valid && retUpd.isCall && !retUpd.cleanRet;
        decIdx = RsIdxT'(retUpd.idx + 1'b1);
        decAddr = PcT'(retUpd.addr + 1'b1);
    end

    // every speculative pop is backed up with the entry it consumed
    always_comb begin
        popRec.valid = retTaken && !mispr.valid;
        popRec.entry.addr = stack[idxReg];
        popRec.entry.idx = idxReg;
        popRec.entry.fetchId = fetchId;
    end

    // single write port, restore first, then decode calls, then fetch pushes
    always_ff @(posedge clk) begin
        if (restoreWr.valid) begin
            stack[restoreWr.entry.idx] <= restoreWr.entry.addr;
        end else if (decCall) begin
            stack[decIdx] <= decAddr;
        end else if (pushCall) begin
            stack[idx] <= pushAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchValid) begin
            curIdx <= idx;
            // a call right before this fetch has not reached the array yet
            if (lastBranch.valid && lastBranch.isCall) begin
                curRetAddr <= pushAddr;
            end else begin
                curRetAddr <= stack[idx];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mispr.valid) begin
            misprIdxQ <= mispr.idx;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idxReg <= '0;
            lastValid <= 1'b0;
            fwdIdx <= 1'b0;
        end else begin
            fwdIdx <= mispr.valid;
            if (mispr.valid) begin
                // the branch after a mispredict belongs to the wrong path
                lastValid <= 1'b0;
            end else begin
                idxReg <= idx;
                lastValid <= fetchValid;
            end
        end
    end

endmodule

// ==== src/retpred_pkg.sv ====
`include "retpred_macros.svh"

package retpred_pkg;

    // halfword aligned pc, bit 0 of the byte address dropped
    typedef logic [30:0] PcT;
    typedef logic [2:0] FetchOffT;
    // wraps around, so ordering is only defined relative to a base
    typedef logic [4:0] FetchIdT;
    typedef logic [$clog2(`RS_SIZE)-1:0] RsIdxT;

    typedef struct packed {
        logic     valid;
        logic     isCall;
        logic     isRet;
        FetchOffT offs;
        PcT       dst;
    } PredBranchT;

    typedef struct packed {
        logic    valid;
        RsIdxT   idx;
        FetchIdT fetchId;
    } MisprT;

    typedef struct packed {
        logic  valid;
        PcT    addr;
        RsIdxT idx;
        logic  isCall;
        logic  isRet;
        logic  cleanRet;
        logic  compr;
    } ReturnUpdT;

    typedef struct packed {
        PcT      addr;
        RsIdxT   idx;
        FetchIdT fetchId;
    } RecEntryT;

    // queue entry with its write strobe, used for pops and restores
    typedef struct packed {
        logic     valid;
        RecEntryT entry;
    } RecWrT;

    typedef struct packed {
        logic     valid;
        FetchOffT offs;
        logic     compr;
        PcT       dst;
    } RetPredT;

    typedef struct packed {
        logic     valid;
        FetchOffT offs;
        logic     compr;
    } RtLookupT;

endpackage

// ==== src/retpred_macros.svh ====
`ifndef RETPRED_MACROS_SVH
`define RETPRED_MACROS_SVH

// return stack depth, power of two so the index wraps around
`define RS_SIZE 8

// recovery queue depth, one slot stays free to tell full from empty
`define RQ_SIZE 4

// return location table geometry
`define RT_SETS 16
`define RT_ASSOC 2

// tag width after xor folding of the fetch pc
`define RT_TAG_LEN 10

`endif
